// ==== besm_cpu.f ====
+incdir+rtl
rtl/besm_pkg.sv
rtl/micro_sequencer.sv
rtl/control_store.sv
rtl/status_flags.sv
rtl/bus_registers.sv
rtl/besm_cpu.sv
verif/besm_cpu_tb.sv

// ==== rtl/besm_consts.svh ====
`ifndef BESM_CONSTS_SVH
`define BESM_CONSTS_SVH

// --------------------------------------------------
// Widths
// --------------------------------------------------
`define UADDR_W      12         // Microaddress
`define UWORD_W      112        // Microinstruction
`define DATA_W       64         // D and Y buses
`define STACK_DEPTH  5          // Return stack entries

// Sequencer opcodes (SQI)
`define SQ_JZ        4'd0       // Jump to zero, clear stack
`define SQ_CJS       4'd1       // Conditional call
`define SQ_JMAP      4'd2       // Jump to the A field
`define SQ_CJP       4'd3       // Conditional jump
`define SQ_CRTN      4'd10      // Conditional return
`define SQ_CONT      4'd14      // Continue

// D bus sources (DSRC)
`define DS_MODGN     4'd1       // Modifier group number
`define DS_PROCN     4'd2       // Process number
`define DS_MODE      4'd3       // Mode register
`define DS_PHYSPG    4'd4       // Physical page
`define DS_SHIFT     4'd9       // Shifter result
`define DS_LITERAL   4'd12      // A field, zero extended

// Y bus destinations (YDST)
`define YD_MODGN     4'd1
`define YD_PROCN     4'd2
`define YD_MODE      4'd3
`define YD_PHYSPG    4'd4
`define YD_UREG      4'd8       // Effective address
`define YD_PSHIFT    4'd9       // Shift parameter

// Y bus devices (YDEV)
`define YV_UREG      3'd3       // Effective address read
`define YV_MPMEM     3'd5       // Exchange memory
`define YV_STOP0     3'd6
`define YV_STOP1     3'd7

// Flag trigger codes (FFCNT)
`define FF_SET_TR0   5'd1
`define FF_CLR_TR0   5'd2
`define FF_SET_TR1   5'd3
`define FF_CLR_TR1   5'd4

// Condition select (COND)
`define COND_YES     5'd0
`define COND_NORMB   5'd1
`define COND_RNDB    5'd2
`define COND_OVRIB   5'd3
`define COND_BNB     5'd4
`define COND_OVRFTB  5'd5
`define COND_DRG     5'd6
`define COND_RCB     5'd8
`define COND_CB      5'd9
`define COND_CEMLRG  5'd10
`define COND_TR1     5'd12
`define COND_INTSTP  5'd13
`define COND_TR0     5'd22

`endif

// ==== rtl/besm_cpu.sv ====
`default_nettype none

`include "besm_consts.svh"

module besm_cpu
    import besm_pkg::*;
(
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 i_load,         // Control store write
    input  wire [`UADDR_W-1:0]  i_load_addr,
    input  wire [`UWORD_W-1:0]  i_load_word,
    output logic [`DATA_W-1:0]  o_y,            // Y bus
    output logic                o_y_valid,
    output logic [`UADDR_W-1:0] o_uaddr,        // Next microaddress
    output logic                o_halt
);

    microinstr_t mi;                            // Current microinstruction
    mode_reg_t   mode;
    logic        cond;

    // --------------------------------------------------
    // Sequencing and control store
    // --------------------------------------------------
    micro_sequencer micro_sequencer_inst (
        .clk         (clk),
        .reset       (reset),
        .i_mi        (mi),
        .i_cond      (cond),
        .i_hold      (o_halt),                  // Stopped machine repeats
        .o_uaddr     (o_uaddr)
    );

    control_store control_store_inst (
        .clk         (clk),
        .reset       (reset),
        .i_load      (i_load),
        .i_load_addr (i_load_addr),
        .i_load_word (i_load_word),
        .i_hold      (o_halt),
        .i_uaddr     (o_uaddr),
        .o_mi        (mi)
    );

    // --------------------------------------------------
    // Flags and datapath registers
    // --------------------------------------------------
    status_flags status_flags_inst (
        .clk         (clk),
        .reset       (reset),
        .i_mi        (mi),
        .i_y         (o_y),
        .o_mode      (mode),
        .o_cond      (cond)
    );

    bus_registers bus_registers_inst (
        .clk         (clk),
        .reset       (reset),
        .i_mi        (mi),
        .i_mode      (mode),
        .o_y         (o_y),
        .o_y_valid   (o_y_valid),
        .o_halt      (o_halt)
    );

endmodule

`default_nettype wire

// ==== rtl/besm_pkg.sv ====
`default_nettype none

`include "besm_consts.svh"

package besm_pkg;

    typedef logic [4:0] cond_code_t;        // COND field

    // Bits 11..7 read as trigger code or exchange address
    typedef union packed {
        logic [4:0] ffcnt;                  // Flag trigger set/clear
        struct packed {
            logic       spare;
            logic [3:0] mpadr;              // Exchange memory address
        } mp;
    } mi_low_u;

    // --------------------------------------------------
    // Microinstruction word, MSB first
    // --------------------------------------------------
    typedef struct packed {
        logic [3:0]          sqi;           // Sequencer opcode
        logic [`UADDR_W-1:0] a;             // Jump address or literal
        logic [1:0]          rsv_map;       // Unused map select
        logic                alu;           // Put D on Y
        logic [2:0]          rsv_alud;
        logic [2:0]          rsv_func;
        logic [2:0]          rsv_alus;
        logic                rsv_h;
        logic [3:0]          rsv_rb;
        logic [3:0]          rsv_ra;
        logic [1:0]          rsv_ci;
        logic [3:0]          rsv_shmux;
        logic [5:0]          rsv_stopc;
        logic                rsv_mod;
        logic [6:0]          pshf;          // Shift direction and count
        logic [3:0]          dsrc;          // D bus source
        logic [3:0]          ydst;          // Y bus destination
        logic [1:0]          shf;           // Shifter op, nonzero latches
        logic [3:0]          rsv_arbi;
        logic                rsv_rld;
        logic                rsv_letc;
        logic [2:0]          rsv_cystr;
        logic                sci;           // Condition into carry
        logic                ici;           // Invert carry
        logic                icc;           // Invert condition
        logic                rsv_ise;
        logic                rsv_cem;
        logic                rsv_cen;
        logic                rsv_csm;
        logic                rsv_wem;
        logic                rsv_ecb;
        logic                rsv_wrb;
        logic [1:0]          rsv_bra;
        logic                rsv_eca;
        logic                rsv_wra;
        logic [1:0]          rsv_ara;
        logic [2:0]          ydev;          // Y device
        logic                wry;           // Y device write
        logic [2:0]          rsv_ddev;
        logic                rsv_wrd;
        logic                iomp;          // 0 selects flag triggers
        mi_low_u             low;           // Bits 11..7
        cond_code_t          cond;          // Condition select
        logic                mps;           // Shift parameter from register
    } microinstr_t;

    // Mode register with normb as BESM bit 1
    typedef struct packed {
        logic [1:0] rsv;
        logic       flag_jump;              // Control transfer
        logic       rcb;                    // Right command
        logic       cb;                     // Address modified by reg 16
        logic       no_paging;
        logic       no_procnm;
        logic       flag_negaddr;           // Negative addresses
        logic       no_rprot;
        logic       no_wprot;
        logic       intstp;                 // Stop on interrupt
        logic       single_step;
        logic       cemlrg;
        logic       no_wtag;
        logic       no_intr;
        logic       no_progtag;
        logic       no_badacc;
        logic       no_rtag;
        logic       no_badop;
        logic       drg;                    // Dispatcher mode
        logic       ovrftb;
        logic       bnb;
        logic       flag_z;
        logic       flag_n;
        logic       flag_c;
        logic       flag_v;
        logic       ovrib;                  // Overflow interrupt block
        logic       grp_add;
        logic       grp_mul;
        logic       grp_log;
        logic       rndb;                   // Rounding block
        logic       normb;                  // Normalization block
    } mode_reg_t;

endpackage

`default_nettype wire

// ==== rtl/bus_registers.sv ====
`default_nettype none

`include "besm_consts.svh"

module bus_registers
    import besm_pkg::*;
(
    input  wire                 clk,
    input  wire                 reset,
    input  wire microinstr_t    i_mi,
    input  wire mode_reg_t      i_mode,
    output logic [`DATA_W-1:0]  o_y,
    output logic                o_y_valid,
    output logic                o_halt          // STOP0 level
);

    logic [4:0]         modgn;                  // Modifier group number
    logic [7:0]         procn;                  // Process number
    logic [9:0]         physpg;                 // Physical page
    logic [31:0]        ureg;                   // Effective address
    logic [6:0]         pshift;                 // Shift parameter register
    logic [`DATA_W-1:0] shift_res;              // Shifter result
    logic [7:0]         mpmem [16];             // Console exchange bytes
    logic               stop0, stop1;
    logic [`DATA_W-1:0] d;                      // D bus
    logic [6:0]         shpar;                  // Active shift parameter
    logic [3:0]         mpadr;

    assign mpadr = i_mi.low.mp.mpadr;
    assign shpar = i_mi.mps ? pshift : i_mi.pshf;

    // --------------------------------------------------
    // D and Y buses
    // --------------------------------------------------
    always_comb begin
        case (i_mi.dsrc)
            `DS_MODGN:   d = {{(`DATA_W-10){1'b0}}, modgn, 5'd0};
            `DS_PROCN:   d = {{(`DATA_W-8){1'b0}}, procn};
            `DS_MODE:    d = {{(`DATA_W-32){1'b0}}, i_mode};
            `DS_PHYSPG:  d = {{(`DATA_W-21){1'b0}}, physpg, 11'd0};
            `DS_SHIFT:   d = shift_res;
            `DS_LITERAL: d = {{(`DATA_W-`UADDR_W){1'b0}}, i_mi.a};
            default:     d = '0;
        endcase
    end

    always_comb begin
        if (!i_mi.wry && i_mi.ydev == `YV_UREG)
            o_y = {{(`DATA_W-32){1'b0}}, ureg};
        else if (!i_mi.wry && i_mi.ydev == `YV_MPMEM)
            o_y = {{(`DATA_W-8){1'b0}}, mpmem[mpadr]};
        else if (!i_mi.wry && i_mi.ydev == `YV_STOP1)
            o_y = {{(`DATA_W-1){1'b0}}, stop1};  // Console side flag
        else if (i_mi.alu)
            o_y = d;                            // D passes straight to Y
        else
            o_y = '0;
    end

    // Destination registers and shifter
    always_ff @(posedge clk) begin
        case (i_mi.ydst)
            `YD_MODGN:  modgn  <= o_y[9:5];
            `YD_PROCN:  procn  <= o_y[7:0];
            `YD_PHYSPG: physpg <= o_y[20:11];
            `YD_UREG:   ureg   <= o_y[31:0];
            `YD_PSHIFT: pshift <= o_y[6:0];
            default: ;
        endcase
        if (i_mi.shf != 2'd0)                   // Bit 6 selects left
            shift_res <= shpar[6] ? o_y << shpar[5:0] : o_y >> shpar[5:0];
    end

    // --------------------------------------------------
    // Exchange memory and stop flags
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_mi.wry && i_mi.ydev == `YV_MPMEM) mpmem[mpadr] <= o_y[7:0];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stop0 <= 1'b0;
            stop1 <= 1'b0;
        end else if (i_mi.wry) begin
            if (i_mi.ydev == `YV_STOP0) stop0 <= o_y[0];
            if (i_mi.ydev == `YV_STOP1) stop1 <= o_y[0];
        end
    end

    assign o_halt    = stop0;
    assign o_y_valid = (i_mi.ydst != 4'd0 || i_mi.wry) && !stop0;

endmodule

`default_nettype wire

// ==== rtl/control_store.sv ====
`default_nettype none

`include "besm_consts.svh"

module control_store
    import besm_pkg::*;
(
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 i_load,         // Write strobe
    input  wire [`UADDR_W-1:0]  i_load_addr,
    input  wire [`UWORD_W-1:0]  i_load_word,
    input  wire                 i_hold,         // Keep current word
    input  wire [`UADDR_W-1:0]  i_uaddr,
    output microinstr_t         o_mi            // Pipeline register
);

    logic [`UWORD_W-1:0] mem [1 << `UADDR_W];   // Writable microprogram

    always_ff @(posedge clk) begin
        if (i_load) mem[i_load_addr] <= i_load_word;
    end

    // Zero word decodes as JZ to address 0
    always_ff @(posedge clk) begin
        if (reset) o_mi <= '0;
        else if (!i_hold) o_mi <= microinstr_t'(mem[i_uaddr]);
    end

endmodule

`default_nettype wire

// ==== rtl/micro_sequencer.sv ====
`default_nettype none

`include "besm_consts.svh"

module micro_sequencer
    import besm_pkg::*;
(
    input  wire                 clk,
    input  wire                 reset,
    input  wire microinstr_t    i_mi,
    input  wire                 i_cond,         // Already inverted per ICC
    input  wire                 i_hold,         // Freeze on stop
    output logic [`UADDR_W-1:0] o_uaddr
);

    localparam int SP_W = $clog2(`STACK_DEPTH + 1);

    logic [`UADDR_W-1:0] upc;                   // Microprogram counter
    logic [`UADDR_W-1:0] stack [`STACK_DEPTH];  // Return addresses
    logic [SP_W-1:0]     sp;                    // Entries in use
    logic [SP_W-1:0]     wr_idx;
    logic [`UADDR_W-1:0] top;
    logic                push, pop, clr;
    logic                ci;                    // Counter carry in

    assign top    = (sp == '0) ? upc : stack[sp - 1'b1];
    assign wr_idx = (sp == SP_W'(`STACK_DEPTH)) ? SP_W'(`STACK_DEPTH - 1) : sp;
    assign ci     = (i_mi.sci ? i_cond : 1'b1) ^ i_mi.ici;

    // --------------------------------------------------
    // Next address select
    // --------------------------------------------------
    always_comb begin
        o_uaddr = upc;                          // CONT and undefined codes
        push    = 1'b0;
        pop     = 1'b0;
        clr     = 1'b0;
        case (i_mi.sqi)
            `SQ_JZ: begin
                o_uaddr = '0;
                clr     = 1'b1;
            end
            `SQ_CJS: begin
                if (i_cond) begin
                    o_uaddr = i_mi.a;
                    push    = 1'b1;             // Save return point
                end
            end
            `SQ_JMAP: o_uaddr = i_mi.a;
            `SQ_CJP: begin
                if (i_cond) o_uaddr = i_mi.a;
            end
            `SQ_CRTN: begin
                if (i_cond) begin
                    o_uaddr = top;
                    pop     = 1'b1;
                end
            end
            `SQ_CONT: o_uaddr = upc;
            default: o_uaddr = upc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            upc <= '0;
            sp  <= '0;                          // Stack empty
        end else if (!i_hold) begin
            upc <= o_uaddr + {{(`UADDR_W-1){1'b0}}, ci};
            if (clr) sp <= '0;
            else if (push && sp != SP_W'(`STACK_DEPTH)) sp <= sp + 1'b1;
            else if (pop && sp != '0) sp <= sp - 1'b1;
        end
    end

    // Full stack overwrites its top entry
    always_ff @(posedge clk) begin
        if (!i_hold && push) stack[wr_idx] <= upc;
    end

endmodule

`default_nettype wire

// ==== rtl/status_flags.sv ====
`default_nettype none

`include "besm_consts.svh"

module status_flags
    import besm_pkg::*;
(
    input  wire                 clk,
    input  wire                 reset,
    input  wire microinstr_t    i_mi,
    input  wire [`DATA_W-1:0]   i_y,
    output mode_reg_t           o_mode,
    output logic                o_cond          // Test result after ICC
);

    logic tr0, tr1;                             // Microprogram flags
    logic condmux;

    always_ff @(posedge clk) begin
        if (reset) begin
            o_mode <= '0;
            tr0    <= 1'b0;
            tr1    <= 1'b0;
        end else begin
            if (i_mi.ydst == `YD_MODE) o_mode <= mode_reg_t'(i_y[31:0]);
            if (!i_mi.iomp) begin               // Trigger decoder selected
                case (i_mi.low.ffcnt)
                    `FF_SET_TR0: tr0 <= 1'b1;
                    `FF_CLR_TR0: tr0 <= 1'b0;
                    `FF_SET_TR1: tr1 <= 1'b1;
                    `FF_CLR_TR1: tr1 <= 1'b0;
                    default: ;
                endcase
            end
        end
    end

    // --------------------------------------------------
    // Condition multiplexer
    // --------------------------------------------------
    always_comb begin
        case (i_mi.cond)
            `COND_YES:    condmux = 1'b1;
            `COND_NORMB:  condmux = o_mode.normb;
            `COND_RNDB:   condmux = o_mode.rndb;
            `COND_OVRIB:  condmux = o_mode.ovrib;
            `COND_BNB:    condmux = o_mode.bnb;
            `COND_OVRFTB: condmux = o_mode.ovrftb;
            `COND_DRG:    condmux = o_mode.drg;
            `COND_RCB:    condmux = o_mode.rcb;
            `COND_CB:     condmux = o_mode.cb;
            `COND_CEMLRG: condmux = o_mode.cemlrg;
            `COND_TR1:    condmux = tr1;
            `COND_INTSTP: condmux = o_mode.intstp;
            `COND_TR0:    condmux = tr0;
            default:      condmux = 1'b0;       // No source behind these codes
        endcase
    end

    assign o_cond = condmux ^ i_mi.icc;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run from the project root
verilator --binary --timing --top-module besm_cpu_tb -f besm_cpu.f -o besm_sim \
    && ./obj_dir/besm_sim | grep "TEST OK" \
    && exit 0 \
    || exit 1

// ==== verif/besm_cpu_tb.sv ====
`default_nettype none

`include "besm_consts.svh"

module besm_cpu_tb
    import besm_pkg::*;
();

    logic                clk;
    logic                reset;
    logic                i_load;
    logic [`UADDR_W-1:0] i_load_addr;
    logic [`UWORD_W-1:0] i_load_word;
    logic [`DATA_W-1:0]  o_y;
    logic                o_y_valid;
    logic [`UADDR_W-1:0] o_uaddr;
    logic                o_halt;

    logic [`UADDR_W-1:0] addr_q [$];            // Load records
    logic [`UWORD_W-1:0] word_q [$];
    logic [`DATA_W-1:0]  exp_q [$];             // Expected Y values
    bit                  halt_expected;
    bit                  checking;
    bit                  loaded;
    int                  errors;
    int                  exp_idx;
    int                  watchdog_cycles;

    besm_cpu besm_cpu_inst (
        .clk         (clk),
        .reset       (reset),
        .i_load      (i_load),
        .i_load_addr (i_load_addr),
        .i_load_word (i_load_word),
        .o_y         (o_y),
        .o_y_valid   (o_y_valid),
        .o_uaddr     (o_uaddr),
        .o_halt      (o_halt)
    );

    always #4 clk = ~clk;                       // 8 unit period

    // --------------------------------------------------
    // Test data parsing
    // --------------------------------------------------
    task automatic read_data_file();
        int          fd;
        int          n;
        string       line;
        string       tag;
        logic [31:0] fv [14];
        logic [63:0] ev;
        microinstr_t m;
        fd = $fopen("verif/besm_cpu_testdata.hex", "r");
        if (fd == 0) begin
            $display("Could not open the test data file");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() <= 1 || line.substr(0, 0) == "#") continue;  // Blank or note
            n = $sscanf(line, "%s", tag);
            if (tag == "L") begin
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h", tag,
                            fv[0], fv[1], fv[2], fv[3], fv[4], fv[5], fv[6],
                            fv[7], fv[8], fv[9], fv[10], fv[11], fv[12], fv[13]);
                m = '0;
                m.sqi       = fv[1][3:0];
                m.a         = fv[2][11:0];      // Jump target or literal
                m.alu       = fv[3][0];
                m.dsrc      = fv[4][3:0];
                m.ydst      = fv[5][3:0];
                m.pshf      = fv[6][6:0];
                m.shf       = fv[7][1:0];
                m.cond      = fv[8][4:0];
                m.icc       = fv[9][0];
                m.ydev      = fv[10][2:0];
                m.wry       = fv[11][0];
                m.iomp      = fv[12][0];
                m.low.ffcnt = fv[13][4:0];      // Raw bits, either view
                addr_q.push_back(fv[0][11:0]);
                word_q.push_back(m);
            end else if (tag == "E") begin
                n = $sscanf(line, "%s %h", tag, ev);
                exp_q.push_back(ev);
            end else if (tag == "H") begin
                halt_expected = 1'b1;
            end else begin
                $display("Unknown record in the test data file: %s", line);
                errors++;
            end
        end
        $fclose(fd);
    endtask

    // Drives the load port on falling edges while reset is high
    task automatic load_microcode();
        int cycles;
        cycles = 0;
        foreach (addr_q[i]) begin
            @(negedge clk);
            i_load      = 1'b1;
            i_load_addr = addr_q[i];
            i_load_word = word_q[i];
            cycles++;
        end
        @(negedge clk);
        i_load = 1'b0;
        cycles++;
        while (cycles < 16) begin
            @(negedge clk);
            cycles++;
        end
        @(negedge clk);
        reset    = 1'b0;
        checking = 1'b1;
    endtask

    // --------------------------------------------------
    // Y bus checker
    // --------------------------------------------------
    always @(posedge clk) begin
        if (checking && o_y_valid) begin
            if (exp_idx >= exp_q.size()) begin
                $display("Y output at %0t with no expected record left", $time);
                errors++;
            end else if (o_y !== exp_q[exp_idx]) begin
                $display("ERROR at %0t: o_y got %h expected %h",
                         $time, o_y, exp_q[exp_idx]);
                errors++;
            end
            exp_idx++;
        end
    end

    initial begin
        wait (loaded);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        i_load        = 1'b0;
        i_load_addr   = '0;
        i_load_word   = '0;
        errors        = 0;
        exp_idx       = 0;
        checking      = 1'b0;
        halt_expected = 1'b0;
        loaded        = 1'b0;
        read_data_file();
        watchdog_cycles = addr_q.size() * 40 + 200;
        loaded = 1'b1;
        load_microcode();
        @(posedge clk);                         // First cycle out of reset
        if (o_uaddr !== '0) begin
            $display("ERROR at %0t: o_uaddr got %h expected %h", $time, o_uaddr, 12'h0);
            errors++;
        end
        if (o_y_valid !== 1'b0) begin
            $display("ERROR at %0t: o_y_valid got %b expected %b", $time, o_y_valid, 1'b0);
            errors++;
        end
        if (o_halt !== 1'b0) begin
            $display("ERROR at %0t: o_halt got %b expected %b", $time, o_halt, 1'b0);
            errors++;
        end
        if (halt_expected) wait (o_halt === 1'b1);
        else wait (exp_idx >= exp_q.size());
        repeat (10) @(posedge clk);             // Watch for stray Y after halt
        if (halt_expected && o_halt !== 1'b1) begin
            $display("The machine did not halt at the end of the microprogram");
            errors++;
        end
        if (exp_idx < exp_q.size()) begin
            $display("Only %0d of %0d expected Y values were seen", exp_idx, exp_q.size());
            errors++;
        end
        $display("Errors: %0d, Y values checked: %0d", errors, exp_idx);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/besm_cpu_testdata.hex ====
# L addr sqi a alu dsrc ydst pshf shf cond icc ydev wry iomp low (all hex)
# E expected_y    H requires halt at the end
L 000 e 3a5 1 c 2 00 0 00 0 0 0 0 00
L 001 e 000 1 2 8 00 0 00 0 0 0 0 00
L 002 e fff 1 c 4 00 0 00 0 0 0 0 00
L 003 e 000 1 4 8 00 0 00 0 0 0 0 00
L 004 e 00b 1 c 3 00 0 00 0 0 0 0 00
L 005 e 000 1 3 8 00 0 00 0 0 0 0 00
L 006 3 008 0 0 0 00 0 01 0 0 0 0 00
L 007 e 111 1 c 8 00 0 00 0 0 0 0 00
L 008 3 00a 0 0 0 00 0 01 1 0 0 0 00
L 009 e 222 1 c 8 00 0 00 0 0 0 0 01
L 00a 3 00c 0 0 0 00 0 16 1 0 0 0 00
L 00b 3 00d 0 0 0 00 0 0c 1 0 0 0 00
L 00c e 333 1 c 8 00 0 00 0 0 0 0 00
L 00d e 444 1 c 8 00 0 00 0 0 0 0 00
L 00e 1 01e 0 0 0 00 0 00 0 0 0 0 00
L 00f e 555 1 c 8 00 0 00 0 0 0 0 00
L 010 e 0f0 1 c 8 44 1 00 0 0 0 0 00
L 011 e 000 1 9 8 08 1 00 0 0 0 0 00
L 012 e 000 1 9 8 00 0 00 0 0 0 0 00
L 013 e 05c 1 c 0 00 0 00 0 5 1 1 03
L 014 e 000 0 0 8 00 0 00 0 5 0 1 03
L 015 e 001 1 c 0 00 0 00 0 6 1 0 00
L 016 e 999 1 c 8 00 0 00 0 0 0 0 00
L 01e e 601 1 c 8 00 0 00 0 0 0 0 00
L 01f 1 028 0 0 0 00 0 00 0 0 0 0 00
L 020 e 602 1 c 8 00 0 00 0 0 0 0 00
L 021 a 000 0 0 0 00 0 00 0 0 0 0 00
L 028 e 701 1 c 8 00 0 00 0 0 0 0 00
L 029 a 000 0 0 0 00 0 00 0 0 0 0 00
E 3a5
E 0a5
E fff
E 800
E 00b
E 00b
E 222
E 444
E 601
E 701
E 602
E 555
E 0f0
E f00
E 00f
E 05c
E 05c
E 001
H
